//--- logic/rv_decode_config.svh
`ifndef RV_DECODE_CONFIG_SVH
`define RV_DECODE_CONFIG_SVH

// datapath
`define RV_XLEN         64      // register and pc width

// instruction queue
`define RV_IQ_DEPTH     16      // entries, power of two
`define RV_IQ_ALM_FULL  12      // ready drops here, 4 left as slack

// machine csr addresses
`define RV_CSR_MSTATUS  12'h300
`define RV_CSR_MTVEC    12'h305
`define RV_CSR_MEPC     12'h341
`define RV_CSR_MCAUSE   12'h342

`endif

//--- logic/rv_decode_pkg.sv
`include "rv_decode_config.svh"

package rv_decode_pkg;

    typedef logic [`RV_XLEN-1:0] xlen_t;     // data word
    typedef logic [31:0]         inst_t;     // raw instruction
    typedef logic [4:0]          reg_idx_t;  // x0..x31
    typedef logic [2:0]          funct3_t;
    typedef logic [11:0]         csr_addr_t;

    // bit positions in the one-hot class vector
    localparam int OPC_LUI     = 0;
    localparam int OPC_AUIPC   = 1;
    localparam int OPC_JAL     = 2;
    localparam int OPC_JALR    = 3;
    localparam int OPC_BRANCH  = 4;
    localparam int OPC_LOAD    = 5;
    localparam int OPC_STORE   = 6;
    localparam int OPC_OP_IMM  = 7;
    localparam int OPC_OP      = 8;   // includes M-extension
    localparam int OPC_OP_IMM32 = 9;
    localparam int OPC_OP32    = 10;  // word ops incl mulw/divw
    localparam int OPC_CSR     = 11;
    localparam int OPC_EBREAK  = 12;
    localparam int OPC_ECALL   = 13;
    localparam int OPC_MRET    = 14;
    localparam int OPC_NUM     = 15;

    typedef logic [OPC_NUM-1:0] op_class_t;  // one-hot, all zero if unknown

endpackage

//--- logic/decode_ifs.sv
`timescale 1ns/10ps

// operand read ports of the register file
interface gpr_rd_if;
    rv_decode_pkg::reg_idx_t rs1;
    rv_decode_pkg::reg_idx_t rs2;
    rv_decode_pkg::xlen_t    rdata1;   // same cycle as rs1
    rv_decode_pkg::xlen_t    rdata2;

    modport reader  (output rs1, output rs2, input rdata1, input rdata2);
    modport regfile (input rs1, input rs2, output rdata1, output rdata2);
endinterface

// decoded view of the held instruction
interface dec_if;
    rv_decode_pkg::reg_idx_t  rd;
    rv_decode_pkg::reg_idx_t  rs1;
    rv_decode_pkg::reg_idx_t  rs2;
    rv_decode_pkg::funct3_t   funct3;
    rv_decode_pkg::xlen_t     imm;
    rv_decode_pkg::op_class_t op_class;
    rv_decode_pkg::xlen_t     src_a;
    rv_decode_pkg::xlen_t     src_b;   // gpr or csr value

    modport source (output rd, rs1, rs2, funct3, imm, op_class, src_a, src_b);
    modport sink   (input rd, rs1, rs2, funct3, imm, op_class, src_a, src_b);
endinterface

//--- logic/inst_queue.sv
`timescale 1ns/10ps
`include "rv_decode_config.svh"

module inst_queue (
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 flush,     // sync clear of all entries
    input  logic                 wr_en,
    input  rv_decode_pkg::xlen_t wr_pc,
    input  rv_decode_pkg::inst_t wr_inst,
    input  logic                 rd_en,
    output rv_decode_pkg::xlen_t rd_pc,     // head entry, comb
    output rv_decode_pkg::inst_t rd_inst,
    output logic                 empty,
    output logic                 alm_full
);
    localparam int PTR_W = $clog2(`RV_IQ_DEPTH);
    localparam int CNT_W = $clog2(`RV_IQ_DEPTH + 1);

    rv_decode_pkg::xlen_t mem_pc   [`RV_IQ_DEPTH];
    rv_decode_pkg::inst_t mem_inst [`RV_IQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;     // occupancy 0..depth
    logic             full;
    logic             do_wr;
    logic             do_rd;

    assign full     = count == CNT_W'(`RV_IQ_DEPTH);
    assign empty    = count == '0;
    assign alm_full = count >= CNT_W'(`RV_IQ_ALM_FULL);
    assign do_wr    = wr_en && !full && !flush;  // overflow write dropped
    assign do_rd    = rd_en && !empty && !flush;
    assign rd_pc    = mem_pc[rd_ptr];
    assign rd_inst  = mem_inst[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            if (do_rd) rd_ptr <= rd_ptr + 1'b1;
            count <= count + CNT_W'(do_wr) - CNT_W'(do_rd);
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem_pc[wr_ptr]   <= wr_pc;
            mem_inst[wr_ptr] <= wr_inst;
        end
    end

endmodule

//--- logic/decode_fields.sv
`timescale 1ns/10ps
`include "rv_decode_config.svh"

module decode_fields (
    input  rv_decode_pkg::inst_t inst,        // holding register contents
    input  logic                 inst_valid,
    input  rv_decode_pkg::xlen_t mstatus,
    input  rv_decode_pkg::xlen_t mtvec,
    input  rv_decode_pkg::xlen_t mepc,
    input  rv_decode_pkg::xlen_t mcause,
    gpr_rd_if.reader             gpr,
    dec_if.source                dec
);
    rv_decode_pkg::inst_t      inst_m;       // zero when slot empty
    rv_decode_pkg::op_class_t  cls;
    rv_decode_pkg::csr_addr_t  csr_addr;
    rv_decode_pkg::xlen_t      csr_val;
    logic [6:0]                opcode;

    assign inst_m   = inst_valid ? inst : '0;
    assign opcode   = inst_m[6:0];
    assign csr_addr = inst_m[31:20];

    // one class bit per major opcode
    assign cls[rv_decode_pkg::OPC_LUI]      = opcode == 7'b0110111;
    assign cls[rv_decode_pkg::OPC_AUIPC]    = opcode == 7'b0010111;
    assign cls[rv_decode_pkg::OPC_JAL]      = opcode == 7'b1101111;
    assign cls[rv_decode_pkg::OPC_JALR]     = opcode == 7'b1100111;
    assign cls[rv_decode_pkg::OPC_BRANCH]   = opcode == 7'b1100011;
    assign cls[rv_decode_pkg::OPC_LOAD]     = opcode == 7'b0000011;
    assign cls[rv_decode_pkg::OPC_STORE]    = opcode == 7'b0100011;
    assign cls[rv_decode_pkg::OPC_OP_IMM]   = opcode == 7'b0010011;
    assign cls[rv_decode_pkg::OPC_OP]       = opcode == 7'b0110011;
    assign cls[rv_decode_pkg::OPC_OP_IMM32] = opcode == 7'b0011011;
    assign cls[rv_decode_pkg::OPC_OP32]     = opcode == 7'b0111011;
    assign cls[rv_decode_pkg::OPC_CSR]      = opcode == 7'b1110011 && inst_m[14:12] != 3'b000;
    assign cls[rv_decode_pkg::OPC_EBREAK]   = inst_m == 32'h0010_0073;  // exact words
    assign cls[rv_decode_pkg::OPC_ECALL]    = inst_m == 32'h0000_0073;
    assign cls[rv_decode_pkg::OPC_MRET]     = inst_m == 32'h3020_0073;

    // immediate by format, I-type for everything else
    always_comb begin
        if (cls[rv_decode_pkg::OPC_LUI] || cls[rv_decode_pkg::OPC_AUIPC])
            dec.imm = {{(`RV_XLEN-32){inst_m[31]}}, inst_m[31:12], 12'b0};
        else if (cls[rv_decode_pkg::OPC_JAL])
            dec.imm = {{(`RV_XLEN-20){inst_m[31]}}, inst_m[19:12], inst_m[20],
                       inst_m[30:21], 1'b0};
        else if (cls[rv_decode_pkg::OPC_BRANCH])
            dec.imm = {{(`RV_XLEN-12){inst_m[31]}}, inst_m[7], inst_m[30:25],
                       inst_m[11:8], 1'b0};
        else if (cls[rv_decode_pkg::OPC_STORE])
            dec.imm = {{(`RV_XLEN-12){inst_m[31]}}, inst_m[31:25], inst_m[11:7]};
        else
            dec.imm = {{(`RV_XLEN-12){inst_m[31]}}, inst_m[31:20]};
    end

    // the four machine csrs visible to decode
    always_comb begin
        case (csr_addr)
            `RV_CSR_MSTATUS: csr_val = mstatus;
            `RV_CSR_MTVEC:   csr_val = mtvec;
            `RV_CSR_MEPC:    csr_val = mepc;
            `RV_CSR_MCAUSE:  csr_val = mcause;
            default:         csr_val = '0;  // unknown csr reads zero
        endcase
    end

    assign gpr.rs1      = inst_m[19:15];
    assign gpr.rs2      = inst_m[24:20];
    assign dec.rs1      = inst_m[19:15];
    assign dec.rs2      = inst_m[24:20];
    assign dec.rd       = inst_m[11:7];
    assign dec.funct3   = inst_m[14:12];
    assign dec.op_class = cls;
    assign dec.src_a    = gpr.rdata1;
    assign dec.src_b    = cls[rv_decode_pkg::OPC_CSR]   ? csr_val :
                          cls[rv_decode_pkg::OPC_ECALL] ? mtvec   :  // trap target
                          cls[rv_decode_pkg::OPC_MRET]  ? mepc    :  // return pc
                                                          gpr.rdata2;

endmodule

//--- logic/gpr_file.sv
`timescale 1ns/10ps

module gpr_file (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    wb_en,
    input  rv_decode_pkg::reg_idx_t wb_rd,
    input  rv_decode_pkg::xlen_t    wb_data,
    gpr_rd_if.regfile               rd
);
    rv_decode_pkg::xlen_t regs [31:1];  // x0 has no storage
    logic                 we;

    assign we = wb_en && wb_rd != '0;   // writes to x0 ignored

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // comb reads, write shows up the cycle after wb_en
    assign rd.rdata1 = (rd.rs1 == '0) ? '0 : regs[rd.rs1];
    assign rd.rdata2 = (rd.rs2 == '0) ? '0 : regs[rd.rs2];

endmodule

//--- logic/decode_stage.sv
`timescale 1ns/10ps

module decode_stage (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     branch_flush,
    input  logic                     valid_in,
    input  rv_decode_pkg::xlen_t     pc_in,
    input  rv_decode_pkg::inst_t     inst_in,
    output logic                     ready_in,
    output logic                     valid_out,
    output rv_decode_pkg::xlen_t     pc_out,
    output rv_decode_pkg::inst_t     inst_out,
    output logic                     hold_valid,   // slot occupied, to decode
    input  logic                     out_ready,
    input  logic                     ex_loading,
    input  rv_decode_pkg::reg_idx_t  ex_rd,
    dec_if.sink                      dec,
    output rv_decode_pkg::reg_idx_t  rd,
    output rv_decode_pkg::reg_idx_t  rs1,
    output rv_decode_pkg::reg_idx_t  rs2,
    output rv_decode_pkg::funct3_t   funct3,
    output rv_decode_pkg::xlen_t     imm,
    output rv_decode_pkg::op_class_t op_class,
    output rv_decode_pkg::xlen_t     src_a,
    output rv_decode_pkg::xlen_t     src_b
);
    rv_decode_pkg::xlen_t hold_pc;
    rv_decode_pkg::inst_t hold_inst;
    rv_decode_pkg::xlen_t q_pc;
    rv_decode_pkg::inst_t q_inst;
    logic                 q_empty;
    logic                 q_alm_full;
    logic                 q_wr;
    logic                 q_rd;
    logic                 advance;
    logic                 bypass;
    logic                 rs2_used;
    logic                 interlock;

    // load-use hazard against the load now in execute
    assign rs2_used  = dec.op_class[rv_decode_pkg::OPC_BRANCH] |
                       dec.op_class[rv_decode_pkg::OPC_STORE]  |
                       dec.op_class[rv_decode_pkg::OPC_OP]     |
                       dec.op_class[rv_decode_pkg::OPC_OP32];
    assign interlock = hold_valid && ex_loading && ex_rd != '0 &&
                       (ex_rd == dec.rs1 || (rs2_used && ex_rd == dec.rs2));

    assign advance  = out_ready && !interlock;
    assign bypass   = advance && q_empty;                  // input skips the queue
    assign q_wr     = valid_in && !bypass && !branch_flush;
    assign q_rd     = advance && !q_empty;
    assign ready_in = !q_alm_full;

    inst_queue u_iq (
        .clk      (clk),
        .arst_n   (arst_n),
        .flush    (branch_flush),
        .wr_en    (q_wr),
        .wr_pc    (pc_in),
        .wr_inst  (inst_in),
        .rd_en    (q_rd),
        .rd_pc    (q_pc),
        .rd_inst  (q_inst),
        .empty    (q_empty),
        .alm_full (q_alm_full)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_valid <= 1'b0;
        end else if (branch_flush) begin
            hold_valid <= 1'b0;                            // flush wins over advance
        end else if (advance) begin
            hold_valid <= q_empty ? valid_in : 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !branch_flush) begin
            hold_pc   <= q_empty ? pc_in   : q_pc;         // head first, keeps order
            hold_inst <= q_empty ? inst_in : q_inst;
        end
    end

    assign valid_out = hold_valid && !interlock;
    assign pc_out    = hold_pc;
    assign inst_out  = hold_inst;

    // decoded fields follow the holding register
    assign rd       = dec.rd;
    assign rs1      = dec.rs1;
    assign rs2      = dec.rs2;
    assign funct3   = dec.funct3;
    assign imm      = dec.imm;
    assign op_class = dec.op_class;
    assign src_a    = dec.src_a;
    assign src_b    = dec.src_b;

endmodule

//--- logic/decode_top.sv
`timescale 1ns/10ps

module decode_top (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     valid_in,
    input  rv_decode_pkg::xlen_t     pc_in,
    input  rv_decode_pkg::inst_t     inst_in,
    output logic                     ready_in,
    output logic                     valid_out,
    output rv_decode_pkg::xlen_t     pc_out,
    output rv_decode_pkg::inst_t     inst_out,
    input  logic                     out_ready,
    output rv_decode_pkg::reg_idx_t  rd,
    output rv_decode_pkg::reg_idx_t  rs1,
    output rv_decode_pkg::reg_idx_t  rs2,
    output rv_decode_pkg::funct3_t   funct3,
    output rv_decode_pkg::xlen_t     imm,
    output rv_decode_pkg::op_class_t op_class,
    output rv_decode_pkg::xlen_t     src_a,
    output rv_decode_pkg::xlen_t     src_b,
    input  logic                     ex_loading,
    input  rv_decode_pkg::reg_idx_t  ex_rd,
    input  logic                     branch_flush,
    input  logic                     wb_en,
    input  rv_decode_pkg::reg_idx_t  wb_rd,
    input  rv_decode_pkg::xlen_t     wb_data,
    input  rv_decode_pkg::xlen_t     mstatus,
    input  rv_decode_pkg::xlen_t     mtvec,
    input  rv_decode_pkg::xlen_t     mepc,
    input  rv_decode_pkg::xlen_t     mcause
);
    logic hold_valid;       // stage slot valid, masks decode

    gpr_rd_if gpr ();
    dec_if    dec ();

    decode_stage u_stage (
        .clk          (clk),
        .arst_n       (arst_n),
        .branch_flush (branch_flush),
        .valid_in     (valid_in),
        .pc_in        (pc_in),
        .inst_in      (inst_in),
        .ready_in     (ready_in),
        .valid_out    (valid_out),
        .pc_out       (pc_out),
        .inst_out     (inst_out),
        .hold_valid   (hold_valid),
        .out_ready    (out_ready),
        .ex_loading   (ex_loading),
        .ex_rd        (ex_rd),
        .dec          (dec.sink),
        .rd           (rd),
        .rs1          (rs1),
        .rs2          (rs2),
        .funct3       (funct3),
        .imm          (imm),
        .op_class     (op_class),
        .src_a        (src_a),
        .src_b        (src_b)
    );

    decode_fields u_fields (
        .inst       (inst_out),      // raw holding register
        .inst_valid (hold_valid),
        .mstatus    (mstatus),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .mcause     (mcause),
        .gpr        (gpr.reader),
        .dec        (dec.source)
    );

    gpr_file u_gpr (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb_en   (wb_en),
        .wb_rd   (wb_rd),
        .wb_data (wb_data),
        .rd      (gpr.regfile)
    );

endmodule

//--- test/decode_checker.sv
`timescale 1ns/10ps
`include "rv_decode_config.svh"

module decode_checker (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     branch_flush,
    input logic                     valid_out,
    input logic                     ex_loading,
    input rv_decode_pkg::reg_idx_t  ex_rd,
    input rv_decode_pkg::reg_idx_t  rs1,        // decoded, zero when slot empty
    input rv_decode_pkg::reg_idx_t  rs2,
    input rv_decode_pkg::op_class_t op_class,
    input logic                     q_wr,       // queue write request
    input logic                     q_rd        // queue pop, only when not empty
);
    logic [5:0] occ;            // shadow occupancy of the queue
    logic       rs2_read;       // classes that read rs2
    logic       load_use;

    assign rs2_read = op_class[rv_decode_pkg::OPC_BRANCH] || op_class[rv_decode_pkg::OPC_STORE] ||
                      op_class[rv_decode_pkg::OPC_OP]     || op_class[rv_decode_pkg::OPC_OP32];
    assign load_use = ex_loading && ex_rd != '0 &&
                      (ex_rd == rs1 || (rs2_read && ex_rd == rs2));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            occ <= '0;
        end else if (branch_flush) begin
            occ <= '0;
        end else begin
            occ <= occ + 6'(q_wr && occ < 6'(`RV_IQ_DEPTH)) - 6'(q_rd);
        end
    end

    no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
        !(q_wr && occ == 6'(`RV_IQ_DEPTH)))
        else $error("instruction queue written while full");

    stall_blocks_valid: assert property (@(posedge clk) disable iff (!arst_n)
        load_use |-> !valid_out)
        else $error("valid_out high during load-use interlock");

    flush_clears_valid: assert property (@(posedge clk) disable iff (!arst_n)
        branch_flush |=> !valid_out)
        else $error("valid_out high in the cycle after a flush");

endmodule

//--- test/decode_tb.sv
`timescale 1ns/10ps
`include "rv_decode_config.svh"

module decode_tb;

    localparam int NUM_CYCLES  = 4000;
    localparam int DRAIN_LIMIT = 200;     // cycles allowed to empty the stage
    localparam logic [6:0] MAJOR [11] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03,
                                          7'h23, 7'h13, 7'h33, 7'h1b, 7'h3b};
    localparam logic [11:0] CSR_PICK [5] = '{`RV_CSR_MSTATUS, `RV_CSR_MTVEC, `RV_CSR_MEPC,
                                             `RV_CSR_MCAUSE, 12'h7c0};  // last unknown

    logic                     clk;
    logic                     arst_n;
    logic                     valid_in;
    rv_decode_pkg::xlen_t     pc_in;
    rv_decode_pkg::inst_t     inst_in;
    logic                     ready_in;
    logic                     valid_out;
    rv_decode_pkg::xlen_t     pc_out;
    rv_decode_pkg::inst_t     inst_out;
    logic                     out_ready;
    rv_decode_pkg::reg_idx_t  rd;
    rv_decode_pkg::reg_idx_t  rs1;
    rv_decode_pkg::reg_idx_t  rs2;
    rv_decode_pkg::funct3_t   funct3;
    rv_decode_pkg::xlen_t     imm;
    rv_decode_pkg::op_class_t op_class;
    rv_decode_pkg::xlen_t     src_a;
    rv_decode_pkg::xlen_t     src_b;
    logic                     ex_loading;
    rv_decode_pkg::reg_idx_t  ex_rd;
    logic                     branch_flush;
    logic                     wb_en;
    rv_decode_pkg::reg_idx_t  wb_rd;
    rv_decode_pkg::xlen_t     wb_data;
    rv_decode_pkg::xlen_t     mstatus;
    rv_decode_pkg::xlen_t     mtvec;
    rv_decode_pkg::xlen_t     mepc;
    rv_decode_pkg::xlen_t     mcause;

    rv_decode_pkg::xlen_t model_regs [32];   // register file copy
    rv_decode_pkg::xlen_t exp_pc_q [$];      // accepted, not yet delivered
    rv_decode_pkg::inst_t exp_inst_q [$];
    rv_decode_pkg::xlen_t next_pc;
    int mismatches;
    int failures;
    int delivered;
    int wait_cycles;
    bit busy;                                // long out_ready gaps
    bit hold_full;                           // oldest pending sits in the slot

    decode_top dut0 (.*);

    bind decode_stage decode_checker u_chk (
        .clk(clk), .arst_n(arst_n), .branch_flush(branch_flush), .valid_out(valid_out),
        .ex_loading(ex_loading), .ex_rd(ex_rd), .rs1(rs1), .rs2(rs2), .op_class(op_class),
        .q_wr(q_wr), .q_rd(q_rd)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;               // 4 ns period
    end

    task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
            mismatches++;
        end
    endtask

    // sign extend the low bits of v
    function automatic rv_decode_pkg::xlen_t sext(input logic [31:0] v, input int bits);
        rv_decode_pkg::xlen_t r;
        r = rv_decode_pkg::xlen_t'(v) << (`RV_XLEN - bits);
        return rv_decode_pkg::xlen_t'($signed(r) >>> (`RV_XLEN - bits));
    endfunction

    function automatic rv_decode_pkg::op_class_t ref_class(input rv_decode_pkg::inst_t w);
        rv_decode_pkg::op_class_t c;
        c = '0;
        case (w[6:0])
            7'h37: c[rv_decode_pkg::OPC_LUI] = 1'b1;
            7'h17: c[rv_decode_pkg::OPC_AUIPC] = 1'b1;
            7'h6f: c[rv_decode_pkg::OPC_JAL] = 1'b1;
            7'h67: c[rv_decode_pkg::OPC_JALR] = 1'b1;
            7'h63: c[rv_decode_pkg::OPC_BRANCH] = 1'b1;
            7'h03: c[rv_decode_pkg::OPC_LOAD] = 1'b1;
            7'h23: c[rv_decode_pkg::OPC_STORE] = 1'b1;
            7'h13: c[rv_decode_pkg::OPC_OP_IMM] = 1'b1;
            7'h33: c[rv_decode_pkg::OPC_OP] = 1'b1;
            7'h1b: c[rv_decode_pkg::OPC_OP_IMM32] = 1'b1;
            7'h3b: c[rv_decode_pkg::OPC_OP32] = 1'b1;
            7'h73: begin                      // system, exact words first
                if (w == 32'h0010_0073) c[rv_decode_pkg::OPC_EBREAK] = 1'b1;
                else if (w == 32'h0000_0073) c[rv_decode_pkg::OPC_ECALL] = 1'b1;
                else if (w == 32'h3020_0073) c[rv_decode_pkg::OPC_MRET] = 1'b1;
                else if (w[14:12] != 3'b000) c[rv_decode_pkg::OPC_CSR] = 1'b1;
            end
            default: ;
        endcase
        return c;
    endfunction

    function automatic rv_decode_pkg::xlen_t ref_imm(input rv_decode_pkg::inst_t w);
        case (w[6:0])
            7'h37, 7'h17: return sext({w[31:12], 12'h000}, 32);                     // U
            7'h6f: return sext({w[31], w[19:12], w[20], w[30:21], 1'b0}, 21);       // J
            7'h63: return sext({w[31], w[7], w[30:25], w[11:8], 1'b0}, 13);         // B
            7'h23: return sext({w[31:25], w[11:7]}, 12);                           // S
            default: return sext(w[31:20], 12);                                    // I
        endcase
    endfunction

    function automatic rv_decode_pkg::xlen_t ref_src_b(input rv_decode_pkg::inst_t w);
        rv_decode_pkg::op_class_t c;
        c = ref_class(w);
        if (c[rv_decode_pkg::OPC_ECALL]) return mtvec;
        if (c[rv_decode_pkg::OPC_MRET]) return mepc;
        if (!c[rv_decode_pkg::OPC_CSR]) return model_regs[w[24:20]];
        case (w[31:20])
            `RV_CSR_MSTATUS: return mstatus;
            `RV_CSR_MTVEC:   return mtvec;
            `RV_CSR_MEPC:    return mepc;
            `RV_CSR_MCAUSE:  return mcause;
            default:         return '0;
        endcase
    endfunction

    // load-use hazard of w against the load in execute
    function automatic bit ref_hazard(input rv_decode_pkg::inst_t w);
        rv_decode_pkg::op_class_t c;
        bit uses_rs2;
        c = ref_class(w);
        uses_rs2 = c[rv_decode_pkg::OPC_BRANCH] || c[rv_decode_pkg::OPC_STORE] ||
                   c[rv_decode_pkg::OPC_OP] || c[rv_decode_pkg::OPC_OP32];
        if (!ex_loading || ex_rd == 5'd0) return 1'b0;
        return ex_rd == w[19:15] || (uses_rs2 && ex_rd == w[24:20]);
    endfunction

    function automatic rv_decode_pkg::inst_t rand_inst();
        rv_decode_pkg::inst_t w;
        int pick;
        pick = $urandom % 16;
        w = $urandom;
        w[19:15] = 5'($urandom % 8);         // few registers, more hazards
        w[24:20] = 5'($urandom % 8);
        if (pick < 11) w[6:0] = MAJOR[pick];
        else if (pick == 11) w = 32'h0000_0073;  // ecall
        else if (pick == 12) w = 32'h3020_0073;  // mret
        else if (pick == 13) w = 32'h0010_0073;  // ebreak
        else w = {CSR_PICK[$urandom % 5], w[19:15], 3'b010, w[11:7], 7'h73};  // csrrs
        return w;
    endfunction

    task automatic drive_inputs(input bit drain);
        valid_in     = !drain && ready_in && ($urandom % 4 != 0);
        pc_in        = valid_in ? next_pc : {$urandom, $urandom};
        inst_in      = valid_in ? rand_inst() : $urandom;
        next_pc      = valid_in ? next_pc + 64'd4 : next_pc;
        out_ready    = drain || (busy ? ($urandom % 8 == 0) : ($urandom % 4 != 0));
        ex_loading   = !drain && ($urandom % 4 == 0);
        ex_rd        = 5'($urandom % 8);
        branch_flush = !drain && ($urandom % 97 == 0);   // rare
        wb_en        = $urandom % 2;
        wb_rd        = 5'($urandom % 8);     // x0 included, must be ignored
        wb_data      = {$urandom, $urandom};
    endtask

    task automatic check_cycle();
        rv_decode_pkg::inst_t w;
        bit stalled;
        bit exp_valid;
        int q_cnt;
        stalled = 1'b0;
        if (hold_full) stalled = ref_hazard(exp_inst_q[0]);
        exp_valid = hold_full && !stalled;
        q_cnt = exp_pc_q.size() - int'(hold_full);   // entries behind the slot
        check_eq(64'(valid_out), 64'(exp_valid), "valid_out");
        check_eq(64'(ready_in), 64'(q_cnt < `RV_IQ_ALM_FULL), "ready_in");
        if (exp_valid) begin
            w = exp_inst_q[0];
            check_eq(pc_out, exp_pc_q[0], "pc_out");
            check_eq(64'(inst_out), 64'(w), "inst_out");
            check_eq(64'(op_class), 64'(ref_class(w)), "op_class");
            check_eq(imm, ref_imm(w), "imm");
            check_eq(64'(rd), 64'(w[11:7]), "rd");
            check_eq(64'(rs1), 64'(w[19:15]), "rs1");
            check_eq(64'(rs2), 64'(w[24:20]), "rs2");
            check_eq(64'(funct3), 64'(w[14:12]), "funct3");
            check_eq(src_a, model_regs[w[19:15]], "src_a");
            check_eq(src_b, ref_src_b(w), "src_b");
        end
        if (exp_valid && out_ready) begin     // handed to execute
            void'(exp_pc_q.pop_front());
            void'(exp_inst_q.pop_front());
            delivered++;
        end
        if (branch_flush) begin               // drops input of this cycle too
            exp_pc_q.delete();
            exp_inst_q.delete();
            hold_full = 1'b0;
        end else begin
            if (out_ready && !stalled) hold_full = q_cnt != 0 || valid_in;  // slot refill
            if (valid_in) begin
                exp_pc_q.push_back(pc_in);
                exp_inst_q.push_back(inst_in);
            end
        end
        if (wb_en && wb_rd != 5'd0) model_regs[wb_rd] = wb_data;
    endtask

    initial begin
        void'($urandom(78));
        arst_n = 1'b0;
        valid_in = 1'b0;
        pc_in = '0;
        inst_in = '0;
        out_ready = 1'b0;
        ex_loading = 1'b0;
        ex_rd = '0;
        branch_flush = 1'b0;
        wb_en = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        mstatus = {$urandom, $urandom};
        mtvec = {$urandom, $urandom};
        mepc = {$urandom, $urandom};
        mcause = {$urandom, $urandom};
        next_pc = 64'h8000_0000;
        mismatches = 0;
        failures = 0;
        delivered = 0;
        busy = 1'b0;
        hold_full = 1'b0;
        foreach (model_regs[i]) model_regs[i] = '0;
        repeat (3) @(posedge clk);
        #1 arst_n = 1'b1;
        @(negedge clk);
        check_eq(64'(valid_out), 64'd0, "valid_out after reset");
        check_eq(64'(ready_in), 64'd1, "ready_in after reset");

        for (int c = 0; c < NUM_CYCLES; c++) begin
            busy = (c / 150) % 3 == 2;        // every third window stalls execute
            @(posedge clk);
            #1 drive_inputs(1'b0);
            @(negedge clk);
            check_cycle();
        end

        wait_cycles = 0;
        while (exp_pc_q.size() != 0 && wait_cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            #1 drive_inputs(1'b1);
            @(negedge clk);
            check_cycle();
            wait_cycles++;
        end
        if (exp_pc_q.size() != 0) begin
            $display("ERROR: timeout, %0d instructions never left the stage", exp_pc_q.size());
            failures++;
        end

        $display("delivered %0d, mismatches %0d, other errors %0d",
                 delivered, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- sim.f
+incdir+logic
logic/rv_decode_pkg.sv
logic/decode_ifs.sv
logic/inst_queue.sv
logic/decode_fields.sv
logic/gpr_file.sv
logic/decode_stage.sv
logic/decode_top.sv
test/decode_checker.sv
test/decode_tb.sv

//--- run_sim.sh
#!/bin/sh
# build and run the decode stage testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f --top-module decode_tb -o decode_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/decode_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "^Simulation passed$"; then
    exit 0
fi
exit 1
